// File: common/eth_rx_pkg.sv
`default_nettype none

package eth_rx_pkg;

    // ====================
    // framing constants
    // ====================

    // preamble repeats before the delimiter
    localparam logic [7:0] preamble_byte = 8'h55;
    localparam logic [7:0] sfd_byte      = 8'hd5;
    localparam int         preamble_len  = 7;

    // frame limits, destination address through fcs
    localparam int min_frame_len = 64;
    localparam int max_frame_len = 1518;

    // inter-frame gap hold-off, in clock cycles
    localparam int ifg_cycles = 12;

    // ====================
    // crc-32
    // ====================

    localparam logic [31:0] crc_init           = 32'hffff_ffff;
    localparam logic [31:0] crc_poly_reflected = 32'hedb8_8320;
    // register value after data plus a good fcs
    localparam logic [31:0] crc_residue        = 32'hc704_dd7b;

    // ====================
    // field types
    // ====================

    // room for max_frame_len plus one saturated overflow count
    localparam int len_w = $clog2(max_frame_len + 1);

    typedef logic [len_w-1:0] frame_len_t;
    typedef logic [5:0][7:0]  mac_addr_t;
    typedef logic [1:0][7:0]  eth_type_t;

    typedef enum logic [1:0] {
        idle,
        preamble,
        frame,
        wait_ifg
    } rx_state_t;

endpackage

`default_nettype wire

// File: common/rx_byte_if.sv
`timescale 1ns/100ps
`default_nettype none

interface rx_byte_if
    import eth_rx_pkg::*;
#(
    parameter int DATA_WIDTH = 8
) ();

    // byte stream, first dst byte through last fcs byte
    logic                  byte_valid;
    logic [DATA_WIDTH-1:0] byte_data;
    logic                  frame_start;

    // end of frame status, only meaningful with frame_end
    logic                  frame_end;
    logic                  frame_bad;
    logic                  crc_bad;
    frame_len_t            frame_length;

    // receiver FSM side
    modport source (
        output byte_valid, byte_data, frame_start,
        output frame_end, frame_bad, crc_bad, frame_length
    );

    // consumers
    modport sink (
        input byte_valid, byte_data, frame_start,
        input frame_end, frame_bad, crc_bad, frame_length
    );

endinterface

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# compile and run the Ethernet receive testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_eth_rx \
    -f verilog.f -Mdir obj_dir -o tb_eth_rx
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

out=$(./obj_dir/tb_eth_rx)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "Everything OK"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1

// File: rx_frame/crc32_checker.sv
`timescale 1ns/100ps
`default_nettype none

module crc32_checker
    import eth_rx_pkg::*;
(
    input  wire       clk,
    input  wire       sync_switch_rst_n,
    input  wire       start,
    input  wire       byte_en,
    input  wire [7:0] data,
    output logic      crc_match
);

    // msb-first form of the reflected polynomial
    function automatic logic [31:0] reflect32(input logic [31:0] v);
        logic [31:0] r;
        for (int i = 0; i < 32; i++) begin
            r[i] = v[31-i];
        end
        return r;
    endfunction

    localparam logic [31:0] crc_poly = reflect32(crc_poly_reflected);

    logic [31:0] crc_q;
    logic [31:0] crc_next;

    // gmii bytes arrive lsb first, so bit 0 goes in first
    always_comb begin
        crc_next = crc_q;
        for (int i = 0; i < 8; i++) begin
            if (crc_next[31] ^ data[i]) begin
                crc_next = {crc_next[30:0], 1'b0} ^ crc_poly;
            end else begin
                crc_next = {crc_next[30:0], 1'b0};
            end
        end
    end

    always_ff @(posedge clk or negedge sync_switch_rst_n) begin
        if (!sync_switch_rst_n) begin
            crc_q <= crc_init;
        end else if (start) begin
            crc_q <= crc_init;
        end else if (byte_en) begin
            crc_q <= crc_next;
        end
    end

    // fcs included, so a clean frame lands on the residue
    assign crc_match = (crc_q == crc_residue);

endmodule

`default_nettype wire

// File: rx_frame/rx_frame_fsm.sv
`timescale 1ns/100ps
`default_nettype none

module rx_frame_fsm
    import eth_rx_pkg::*;
(
    input  wire        clk,
    input  wire        sync_switch_rst_n,

    input  wire  [7:0] gmii_rx_data,
    input  wire        gmii_rx_dv,
    input  wire        gmii_rx_er,

    rx_byte_if.source  rx,
    output logic       preamble_err
);

    localparam int ifg_w = $clog2(ifg_cycles);

    // gmii sample stage
    logic [7:0]       data_q;
    logic             dv_q;
    logic             er_q;

    rx_state_t        state_q;
    rx_state_t        state_d;
    logic [2:0]       pre_cnt_q;
    frame_len_t       byte_cnt_q;
    logic [ifg_w-1:0] ifg_cnt_q;

    logic             crc_start;
    logic             crc_en;
    logic             crc_match;
    logic             frame_done;
    logic             len_bad;

    // ====================
    // next state
    // ====================

    always_comb begin
        state_d    = state_q;
        crc_start  = 1'b0;
        crc_en     = 1'b0;
        frame_done = 1'b0;
        case (state_q)
            idle: begin
                // first clean preamble byte opens the hunt
                if (dv_q && !er_q && data_q == preamble_byte) begin
                    state_d = preamble;
                end
            end
            preamble: begin
                if (!dv_q || er_q) begin
                    state_d = idle;
                end else if (pre_cnt_q == 3'(preamble_len)) begin
                    // all preamble bytes seen, need the delimiter now
                    if (data_q == sfd_byte) begin
                        state_d   = frame;
                        crc_start = 1'b1;
                    end else begin
                        state_d = idle;
                    end
                end else if (data_q != preamble_byte) begin
                    state_d = idle;
                end
            end
            frame: begin
                if (dv_q && !er_q) begin
                    crc_en = 1'b1;
                end else begin
                    // dv drop or error closes the frame
                    frame_done = 1'b1;
                    state_d    = wait_ifg;
                end
            end
            wait_ifg: begin
                if (ifg_cnt_q == ifg_w'(ifg_cycles - 1)) begin
                    state_d = idle;
                end
            end
            default: state_d = idle;
        endcase
    end

    // length limits on the saturated count
    assign len_bad = (byte_cnt_q < frame_len_t'(min_frame_len)) ||
                     (byte_cnt_q > frame_len_t'(max_frame_len));

    crc32_checker crc32_checker_i (
        .clk               (clk),
        .sync_switch_rst_n (sync_switch_rst_n),
        .start             (crc_start),
        .byte_en           (crc_en),
        .data              (data_q),
        .crc_match         (crc_match)
    );

    // ====================
    // control registers
    // ====================

    always_ff @(posedge clk or negedge sync_switch_rst_n) begin
        if (!sync_switch_rst_n) begin
            dv_q           <= 1'b0;
            er_q           <= 1'b0;
            state_q        <= idle;
            pre_cnt_q      <= '0;
            byte_cnt_q     <= '0;
            ifg_cnt_q      <= '0;
            rx.byte_valid  <= 1'b0;
            rx.frame_start <= 1'b0;
            rx.frame_end   <= 1'b0;
            preamble_err   <= 1'b0;
        end else begin
            dv_q           <= gmii_rx_dv;
            er_q           <= gmii_rx_er;
            state_q        <= state_d;
            rx.byte_valid  <= crc_en;
            rx.frame_start <= crc_en && byte_cnt_q == '0;
            rx.frame_end   <= frame_done;
            // error while still in the preamble
            preamble_err   <= (state_q == preamble) && er_q;
            // idle preloads one, the byte that opened the preamble
            pre_cnt_q <= (state_q == preamble) ? pre_cnt_q + 3'd1 : 3'd1;
            if (crc_start) begin
                byte_cnt_q <= '0;
            end else if (crc_en && byte_cnt_q != frame_len_t'(max_frame_len + 1)) begin
                byte_cnt_q <= byte_cnt_q + 1'b1;
            end
            ifg_cnt_q <= (state_q == wait_ifg) ? ifg_cnt_q + 1'b1 : '0;
        end
    end

    // data path and end of frame status
    always_ff @(posedge clk) begin
        data_q       <= gmii_rx_data;
        rx.byte_data <= data_q;
        if (frame_done) begin
            rx.frame_bad    <= er_q || len_bad || !crc_match;
            rx.crc_bad      <= !crc_match;
            rx.frame_length <= byte_cnt_q;
        end
    end

endmodule

`default_nettype wire

// File: testbench/eth_frame_gen.svh
`ifndef ETH_FRAME_GEN_SVH
`define ETH_FRAME_GEN_SVH

// frame being sent, destination address through fcs
logic [7:0] frame_buf [0:2047];

// ====================
// reference crc
// ====================

// standard reflected crc-32 over the first n bytes, final inversion included
function automatic logic [31:0] crc32_ref(input int n);
    logic [31:0] c;
    c = 32'hffff_ffff;
    for (int i = 0; i < n; i++) begin
        c = c ^ {24'h0, frame_buf[i]};
        for (int b = 0; b < 8; b++) begin
            c = c[0] ? ((c >> 1) ^ 32'hedb8_8320) : (c >> 1);
        end
    end
    return ~c;
endfunction

// true when the last four of n bytes are the fcs of the rest
function automatic logic fcs_ok(input int n);
    logic [31:0] c;
    if (n < 4) begin
        return 1'b0;
    end
    c = crc32_ref(n - 4);
    // fcs goes out low byte first
    return {frame_buf[n-1], frame_buf[n-2], frame_buf[n-3], frame_buf[n-4]} == c;
endfunction

// random header and payload, then the fcs
task automatic build_frame(input int len);
    logic [31:0] fcs;
    for (int i = 0; i < len - 4; i++) begin
        frame_buf[i] = 8'($urandom);
    end
    fcs = crc32_ref(len - 4);
    frame_buf[len-4] = fcs[7:0];
    frame_buf[len-3] = fcs[15:8];
    frame_buf[len-2] = fcs[23:16];
    frame_buf[len-1] = fcs[31:24];
endtask

// ====================
// gmii drive
// ====================

// one byte per rising edge
task automatic drive_byte(input logic [7:0] d, input logic dv, input logic er);
    @(posedge clk);
    gmii_rx_data <= d;
    gmii_rx_dv   <= dv;
    gmii_rx_er   <= er;
endtask

// pre_er and er_at pick the byte that carries gmii_rx_er, -1 for none
task automatic send_frame(input int len, input int pre_er, input logic [7:0] sfd,
                          input int er_at);
    int stop;
    // an error inside the frame also ends it
    stop = (er_at >= 0) ? er_at + 1 : len;
    for (int i = 0; i < preamble_len; i++) begin
        drive_byte(preamble_byte, 1'b1, i == pre_er);
    end
    drive_byte(sfd, 1'b1, 1'b0);
    for (int i = 0; i < stop; i++) begin
        drive_byte(frame_buf[i], 1'b1, i == er_at);
    end
    // idle gap, longer than the ifg hold-off
    repeat (16) drive_byte(8'h00, 1'b0, 1'b0);
endtask

`endif

// File: testbench/tb_eth_rx.sv
`timescale 1ns/100ps
`default_nettype none

module tb_eth_rx
    import eth_rx_pkg::*;
();

    localparam int block_size = 8;

    logic                        clk;
    logic                        sync_switch_rst_n;
    logic [7:0]                  gmii_rx_data;
    logic                        gmii_rx_dv;
    logic                        gmii_rx_er;

    mac_addr_t                   mac_dst_addr;
    mac_addr_t                   mac_src_addr;
    eth_type_t                   mac_type;
    logic                        mac_dst_valid;
    logic                        mac_src_valid;
    logic                        mac_type_valid;

    logic [block_size-1:0][7:0]  frame_data;
    logic                        frame_valid;
    logic                        frame_eof;
    logic                        frame_error;
    frame_len_t                  frame_length;

    logic [31:0]                 rx_frame_count;
    logic [31:0]                 rx_error_count;
    logic [31:0]                 crc_error_count;
    logic [31:0]                 preamble_error_count;

    // ====================
    // scoreboard state
    // ====================

    // bytes still to come out for all frames back to back
    logic [7:0]  exp_bytes[$];
    // delivered byte count and error flag per frame
    int          exp_cnt_q[$];
    logic        exp_err_q[$];
    // tagged header fields in arrival order with dst 0 src 1 type 2
    logic [49:0] exp_hdr_q[$];
    int          got_bytes = 0;

    // model of the statistics block
    int exp_frames = 0;
    int exp_errs = 0;
    int exp_crc = 0;
    int exp_pre = 0;

    int check_errs = 0;
    int timeout_errs = 0;

    eth_rx_top #(.BLOCK_SIZE(block_size)) eth_rx_top_i (
        .clk                  (clk),
        .sync_switch_rst_n    (sync_switch_rst_n),
        .gmii_rx_data         (gmii_rx_data),
        .gmii_rx_dv           (gmii_rx_dv),
        .gmii_rx_er           (gmii_rx_er),
        .mac_dst_addr         (mac_dst_addr),
        .mac_src_addr         (mac_src_addr),
        .mac_type             (mac_type),
        .mac_dst_valid        (mac_dst_valid),
        .mac_src_valid        (mac_src_valid),
        .mac_type_valid       (mac_type_valid),
        .frame_data           (frame_data),
        .frame_valid          (frame_valid),
        .frame_eof            (frame_eof),
        .frame_error          (frame_error),
        .frame_length         (frame_length),
        .rx_frame_count       (rx_frame_count),
        .rx_error_count       (rx_error_count),
        .crc_error_count      (crc_error_count),
        .preamble_error_count (preamble_error_count)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    `include "eth_frame_gen.svh"

    task automatic report_mismatch(input string what, input logic [63:0] got,
                                   input logic [63:0] exp);
        check_errs++;
        $display("Fail at %0t: %s got %h expected %h", $time, what, got, exp);
    endtask

    task automatic report_unexpected(input string what);
        check_errs++;
        $display("%s at time %0t", what, $time);
    endtask

    // ====================
    // output checks
    // ====================

    // header pulses arrive dst, src, type
    task automatic check_header(input logic [1:0] tag, input logic [47:0] got);
        logic [49:0] e;
        if (exp_hdr_q.size() == 0) begin
            report_unexpected("header valid pulse with no header pending");
            return;
        end
        e = exp_hdr_q.pop_front();
        assert (e[49:48] == tag) else report_mismatch("header field tag", tag, e[49:48]);
        assert (e[47:0] == got) else report_mismatch("header field", got, e[47:0]);
    endtask

    task automatic check_block();
        int n;
        logic [7:0] b;
        if (exp_cnt_q.size() == 0) begin
            report_unexpected("frame block with no frame pending");
            return;
        end
        n = frame_eof ? exp_cnt_q[0] - got_bytes : block_size;
        if (frame_eof) begin
            assert (n >= 1 && n <= block_size) else report_mismatch("bytes in eof block", n, 0);
        end else begin
            // a block that ends the frame is held for frame_end
            assert (got_bytes + block_size < exp_cnt_q[0])
                else report_mismatch("bytes before eof", got_bytes + block_size, exp_cnt_q[0]);
        end
        for (int i = 0; i < block_size; i++) begin
            b = 8'h00;
            if (i < n && exp_bytes.size() != 0) begin
                b = exp_bytes.pop_front();
            end
            // padding lanes past the last byte must be zero
            assert (frame_data[i] == b)
                else report_mismatch($sformatf("frame_data lane %0d", i), frame_data[i], b);
        end
        if (frame_eof) begin
            // drop the bytes of blocks that never came
            repeat (n - block_size) begin
                if (exp_bytes.size() != 0) begin
                    exp_bytes.delete(0);
                end
            end
            assert (frame_error == exp_err_q[0])
                else report_mismatch("frame_error", frame_error, exp_err_q[0]);
            assert (frame_length == frame_len_t'(exp_cnt_q[0]))
                else report_mismatch("frame_length", frame_length, exp_cnt_q[0]);
            exp_cnt_q.delete(0);
            exp_err_q.delete(0);
            got_bytes = 0;
        end else begin
            got_bytes += block_size;
        end
    endtask

    // outputs are settled at the falling edge
    always @(negedge clk) begin
        if (sync_switch_rst_n) begin
            if (mac_dst_valid) begin
                check_header(2'd0, mac_dst_addr);
            end
            if (mac_src_valid) begin
                check_header(2'd1, mac_src_addr);
            end
            if (mac_type_valid) begin
                check_header(2'd2, {32'h0, mac_type});
            end
            if (frame_valid) begin
                check_block();
            end
        end
    end

    eof_with_valid: assert property (@(posedge clk) disable iff (!sync_switch_rst_n)
        frame_eof |-> frame_valid)
        else begin
            check_errs++;
            $display("Fail at %0t: frame_eof high without frame_valid", $time);
        end

    hdr_one_at_a_time: assert property (@(posedge clk) disable iff (!sync_switch_rst_n)
        !(mac_dst_valid && (mac_src_valid || mac_type_valid)))
        else begin
            check_errs++;
            $display("Fail at %0t: header valids overlap", $time);
        end

    // ====================
    // test sequence
    // ====================

    function automatic logic [47:0] field_at(input int first, input int len);
        logic [47:0] v;
        v = '0;
        for (int i = first; i < first + len; i++) begin
            v = {v[39:0], frame_buf[i]};
        end
        return v;
    endfunction

    // n bytes come out and each field only if its last byte does
    task automatic expect_frame(input int n, input logic err);
        for (int i = 0; i < n; i++) begin
            exp_bytes.push_back(frame_buf[i]);
        end
        exp_cnt_q.push_back(n);
        exp_err_q.push_back(err);
        if (n >= 6) begin
            exp_hdr_q.push_back({2'd0, field_at(0, 6)});
        end
        if (n >= 12) begin
            exp_hdr_q.push_back({2'd1, field_at(6, 6)});
        end
        if (n >= 14) begin
            exp_hdr_q.push_back({2'd2, field_at(12, 2)});
        end
    endtask

    task automatic wait_drained();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while ((exp_cnt_q.size() != 0 || exp_hdr_q.size() != 0) && cycles < 200) begin
            @(negedge clk);
            cycles++;
        end
        if (exp_cnt_q.size() != 0 || exp_hdr_q.size() != 0) begin
            timeout_errs++;
            $display("timeout: frame outputs still missing after %0d cycles", cycles);
            // resync for the next frame
            exp_bytes.delete();
            exp_cnt_q.delete();
            exp_err_q.delete();
            exp_hdr_q.delete();
            got_bytes = 0;
        end
    endtask

    task automatic check_counters();
        assert (rx_frame_count == exp_frames)
            else report_mismatch("rx_frame_count", rx_frame_count, exp_frames);
        assert (rx_error_count == exp_errs)
            else report_mismatch("rx_error_count", rx_error_count, exp_errs);
        assert (crc_error_count == exp_crc)
            else report_mismatch("crc_error_count", crc_error_count, exp_crc);
        assert (preamble_error_count == exp_pre)
            else report_mismatch("preamble_error_count", preamble_error_count, exp_pre);
    endtask

    task automatic run_frame(input int len, input int pre_er, input logic [7:0] sfd,
                             input int er_at, input logic bad_fcs);
        int n;
        logic crc_good;
        logic err;
        build_frame(len);
        if (bad_fcs) begin
            frame_buf[len-1] = frame_buf[len-1] ^ 8'h80;
        end
        if (pre_er >= 0 || sfd != sfd_byte) begin
            // never reaches the frame state so nothing comes out
            if (pre_er >= 0) begin
                exp_pre++;
            end
        end else begin
            n = (er_at >= 0) ? er_at : len;
            crc_good = fcs_ok(n);
            err = (er_at >= 0) || n < min_frame_len || n > max_frame_len || !crc_good;
            expect_frame(n, err);
            exp_frames++;
            exp_errs += int'(err);
            exp_crc += int'(!crc_good);
        end
        send_frame(len, pre_er, sfd, er_at);
        wait_drained();
        check_counters();
    endtask

    function automatic int random_len();
        return min_frame_len + int'($urandom % (max_frame_len - min_frame_len + 1));
    endfunction

    initial begin
        int seed_val;
        sync_switch_rst_n = 1'b0;
        gmii_rx_data = 8'h00;
        gmii_rx_dv = 1'b0;
        gmii_rx_er = 1'b0;
        seed_val = $urandom(32'h475e_3e51);
        repeat (2) @(posedge clk);
        sync_switch_rst_n <= 1'b1;
        repeat (4) @(posedge clk);

        // shortest and longest legal frames then random lengths
        run_frame(64, -1, sfd_byte, -1, 1'b0);
        run_frame(max_frame_len, -1, sfd_byte, -1, 1'b0);
        repeat (6) run_frame(random_len(), -1, sfd_byte, -1, 1'b0);
        // one flipped fcs bit
        run_frame(random_len(), -1, sfd_byte, -1, 1'b1);
        // runt with a good crc
        run_frame(40, -1, sfd_byte, -1, 1'b0);
        // gmii error halfway through
        run_frame(200, -1, sfd_byte, 100, 1'b0);
        // gmii error on the byte after a good fcs
        run_frame(100, -1, sfd_byte, 100, 1'b0);
        // aborted preamble and a wrong delimiter
        run_frame(100, 3, sfd_byte, -1, 1'b0);
        run_frame(100, -1, 8'hd4, -1, 1'b0);
        // receiver back to normal
        run_frame(random_len(), -1, sfd_byte, -1, 1'b0);

        $display("errors: %0d check failures, %0d timeouts", check_errs, timeout_errs);
        if (check_errs == 0 && timeout_errs == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+testbench
common/eth_rx_pkg.sv
common/rx_byte_if.sv
rx_frame/crc32_checker.sv
rx_frame/rx_frame_fsm.sv
verilog/header_extractor.sv
verilog/block_packer.sv
verilog/rx_stats.sv
verilog/eth_rx_top.sv
testbench/tb_eth_rx.sv

// File: verilog/block_packer.sv
`timescale 1ns/100ps
`default_nettype none

module block_packer
    import eth_rx_pkg::*;
#(
    parameter int BLOCK_SIZE = 8
) (
    input  wire                        clk,
    input  wire                        sync_switch_rst_n,
    rx_byte_if.sink                    rx,

    output logic [BLOCK_SIZE-1:0][7:0] frame_data,
    output logic                       frame_valid,
    output logic                       frame_eof,
    output logic                       frame_error,
    output frame_len_t                 frame_length
);

    localparam int lane_w = $clog2(BLOCK_SIZE);

    // block being filled with unused lanes kept zero
    logic [BLOCK_SIZE-1:0][7:0] acc;
    logic [lane_w-1:0]          lane_q;
    logic [lane_w-1:0]          lane_idx;
    // acc holds a full block not yet known to be last
    logic                       full_q;

    // frame_start forces lane 0 whatever the leftover count
    assign lane_idx = rx.frame_start ? '0 : lane_q;

    // ====================
    // lane tracking
    // ====================

    always_ff @(posedge clk or negedge sync_switch_rst_n) begin
        if (!sync_switch_rst_n) begin
            lane_q      <= '0;
            full_q      <= 1'b0;
            frame_valid <= 1'b0;
            frame_eof   <= 1'b0;
        end else begin
            frame_valid <= 1'b0;
            frame_eof   <= 1'b0;
            if (rx.byte_valid) begin
                // a new byte proves the held block was not the last
                frame_valid <= full_q;
                full_q      <= (lane_idx == lane_w'(BLOCK_SIZE - 1));
                // power of two size wraps by itself
                lane_q      <= lane_idx + 1'b1;
            end else if (rx.frame_end) begin
                frame_valid <= 1'b1;
                frame_eof   <= 1'b1;
                full_q      <= 1'b0;
            end
        end
    end

    // ====================
    // block data
    // ====================

    always_ff @(posedge clk) begin
        if (rx.byte_valid) begin
            if (full_q) begin
                frame_data <= acc;
            end
            // fresh block starts zero padded
            if (lane_idx == '0) begin
                acc <= '0;
            end
            acc[lane_idx] <= rx.byte_data;
        end else if (rx.frame_end) begin
            frame_data   <= acc;
            frame_error  <= rx.frame_bad;
            frame_length <= rx.frame_length;
            // an empty next frame must not see stale bytes
            acc          <= '0;
        end
    end

endmodule

`default_nettype wire

// File: verilog/eth_rx_top.sv
`timescale 1ns/100ps
`default_nettype none

module eth_rx_top
    import eth_rx_pkg::*;
#(
    parameter int DATA_WIDTH = 8,
    parameter int BLOCK_SIZE = 8
) (
    input  wire                                  clk,
    input  wire                                  sync_switch_rst_n,

    // gmii receive pins
    input  wire  [DATA_WIDTH-1:0]                gmii_rx_data,
    input  wire                                  gmii_rx_dv,
    input  wire                                  gmii_rx_er,

    // header fields for mac learning and lookup
    output mac_addr_t                            mac_dst_addr,
    output mac_addr_t                            mac_src_addr,
    output eth_type_t                            mac_type,
    output logic                                 mac_dst_valid,
    output logic                                 mac_src_valid,
    output logic                                 mac_type_valid,

    // packed frame blocks
    output logic [BLOCK_SIZE-1:0][DATA_WIDTH-1:0] frame_data,
    output logic                                 frame_valid,
    output logic                                 frame_eof,
    output logic                                 frame_error,
    output frame_len_t                           frame_length,

    // statistics
    output logic [31:0]                          rx_frame_count,
    output logic [31:0]                          rx_error_count,
    output logic [31:0]                          crc_error_count,
    output logic [31:0]                          preamble_error_count
);

    // in-frame byte stream shared by all consumers
    rx_byte_if #(.DATA_WIDTH(DATA_WIDTH)) rx_bus ();

    logic preamble_err;

    // ====================
    // receive path
    // ====================

    rx_frame_fsm rx_frame_fsm_i (
        .clk               (clk),
        .sync_switch_rst_n (sync_switch_rst_n),
        .gmii_rx_data      (gmii_rx_data),
        .gmii_rx_dv        (gmii_rx_dv),
        .gmii_rx_er        (gmii_rx_er),
        .rx                (rx_bus),
        .preamble_err      (preamble_err)
    );

    header_extractor header_extractor_i (
        .clk               (clk),
        .sync_switch_rst_n (sync_switch_rst_n),
        .rx                (rx_bus),
        .mac_dst_addr      (mac_dst_addr),
        .mac_src_addr      (mac_src_addr),
        .mac_type          (mac_type),
        .mac_dst_valid     (mac_dst_valid),
        .mac_src_valid     (mac_src_valid),
        .mac_type_valid    (mac_type_valid)
    );

    block_packer #(.BLOCK_SIZE(BLOCK_SIZE)) block_packer_i (
        .clk               (clk),
        .sync_switch_rst_n (sync_switch_rst_n),
        .rx                (rx_bus),
        .frame_data        (frame_data),
        .frame_valid       (frame_valid),
        .frame_eof         (frame_eof),
        .frame_error       (frame_error),
        .frame_length      (frame_length)
    );

    rx_stats rx_stats_i (
        .clk                  (clk),
        .sync_switch_rst_n    (sync_switch_rst_n),
        .rx                   (rx_bus),
        .preamble_err         (preamble_err),
        .rx_frame_count       (rx_frame_count),
        .rx_error_count       (rx_error_count),
        .crc_error_count      (crc_error_count),
        .preamble_error_count (preamble_error_count)
    );

endmodule

`default_nettype wire

// File: verilog/header_extractor.sv
`timescale 1ns/100ps
`default_nettype none

module header_extractor
    import eth_rx_pkg::*;
(
    input  wire      clk,
    input  wire      sync_switch_rst_n,
    rx_byte_if.sink  rx,

    output mac_addr_t mac_dst_addr,
    output mac_addr_t mac_src_addr,
    output eth_type_t mac_type,
    output logic      mac_dst_valid,
    output logic      mac_src_valid,
    output logic      mac_type_valid
);

    // last header byte index seen, parks at 14
    logic [3:0] cnt_q;
    // 1-based index of the byte on the bus
    logic [3:0] idx;

    assign idx = rx.frame_start ? 4'd1 : cnt_q + 4'd1;

    // ====================
    // byte index and pulses
    // ====================

    always_ff @(posedge clk or negedge sync_switch_rst_n) begin
        if (!sync_switch_rst_n) begin
            cnt_q          <= '0;
            mac_dst_valid  <= 1'b0;
            mac_src_valid  <= 1'b0;
            mac_type_valid <= 1'b0;
        end else begin
            // one pulse per field, after its last byte
            mac_dst_valid  <= rx.byte_valid && idx == 4'd6;
            mac_src_valid  <= rx.byte_valid && idx == 4'd12;
            mac_type_valid <= rx.byte_valid && idx == 4'd14;
            if (rx.byte_valid && idx != 4'd15) begin
                cnt_q <= idx;
            end
        end
    end

    // fields shift in network order, first byte ends up on top
    always_ff @(posedge clk) begin
        if (rx.byte_valid) begin
            if (idx <= 4'd6) begin
                mac_dst_addr <= {mac_dst_addr[4:0], rx.byte_data};
            end else if (idx <= 4'd12) begin
                mac_src_addr <= {mac_src_addr[4:0], rx.byte_data};
            end else if (idx <= 4'd14) begin
                mac_type <= {mac_type[0], rx.byte_data};
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/rx_stats.sv
`timescale 1ns/100ps
`default_nettype none

module rx_stats (
    input  wire         clk,
    input  wire         sync_switch_rst_n,
    rx_byte_if.sink     rx,
    input  wire         preamble_err,

    output logic [31:0] rx_frame_count,
    output logic [31:0] rx_error_count,
    output logic [31:0] crc_error_count,
    output logic [31:0] preamble_error_count
);

    // counters wrap, only a reset clears them
    always_ff @(posedge clk or negedge sync_switch_rst_n) begin
        if (!sync_switch_rst_n) begin
            rx_frame_count       <= '0;
            rx_error_count       <= '0;
            crc_error_count      <= '0;
            preamble_error_count <= '0;
        end else begin
            // every closed frame, good or bad
            if (rx.frame_end) begin
                rx_frame_count <= rx_frame_count + 1'b1;
            end
            // any error, crc included
            if (rx.frame_end && rx.frame_bad) begin
                rx_error_count <= rx_error_count + 1'b1;
            end
            if (rx.frame_end && rx.crc_bad) begin
                crc_error_count <= crc_error_count + 1'b1;
            end
            // aborted preambles never reach frame_end
            if (preamble_err) begin
                preamble_error_count <= preamble_error_count + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire
